// ==== source/int_mem_pkg.sv ====
package int_mem_pkg;

   // byte address width of both cpu buses
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // master to slave request, zero strobe is a read
   typedef struct packed {
      logic                valid;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
   } iob_req_t;

   // slave to master response
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_resp_t;

   // boot controller state
   typedef enum logic [1:0] {
      BOOT_COPY,
      BOOT_RUN,
      BOOT_RESET,
      CPU_RUN
   } boot_state_e;

endpackage

// ==== source/int_mem_boot_ctrl.sv ====
module int_mem_boot_ctrl
   import int_mem_pkg::*;
#(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 8,
   parameter int RESET_PULSE    = 4
) (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  iob_req_t                  req_i,
   output iob_resp_t                 resp_o,
   output iob_req_t                  preload_req_o,
   output logic                      rom_r_valid_o,
   output logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  logic [DATA_W-1:0]         rom_r_rdata_i,
   output logic                      boot_o,
   output logic                      cpu_reset_o
);

   localparam int PULSE_W = $clog2(RESET_PULSE + 1);
   localparam logic [BOOTROM_ADDR_W-3:0] LAST_WORD = '1;
   // boot program lands at the top of the sram
   localparam logic [ADDR_W-1:0] PRELOAD_BASE =
      ADDR_W'(2**SRAM_ADDR_W - 2**BOOTROM_ADDR_W);

   boot_state_e               state_q;
   logic                      boot_q;
   logic [PULSE_W-1:0]        pulse_q;
   logic [BOOTROM_ADDR_W-2:0] rd_cnt_q;
   logic                      wr_pend_q;
   logic [BOOTROM_ADDR_W-3:0] wr_idx_q;
   logic                      rvalid_q;
   logic                      reg_wr;

   assign reg_wr = req_i.valid && (|req_i.wstrb);

   // register and reset pulse sequencing
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= BOOT_COPY;
         boot_q  <= 1'b1;
         pulse_q <= '0;
      end else begin
         case (state_q)
            BOOT_COPY: begin
               if (wr_pend_q && (wr_idx_q == LAST_WORD)) begin
                  state_q <= BOOT_RUN;
               end
            end
            BOOT_RESET: begin
               if (pulse_q == '0) begin
                  state_q <= boot_q ? BOOT_RUN : CPU_RUN;
               end else begin
                  pulse_q <= pulse_q - 1'b1;
               end
            end
            default: begin
               if (reg_wr) begin
                  boot_q <= req_i.wdata[0];
                  if (req_i.wdata[1]) begin
                     state_q <= BOOT_RESET;
                     pulse_q <= PULSE_W'(RESET_PULSE - 1);
                  end else begin
                     state_q <= req_i.wdata[0] ? BOOT_RUN : CPU_RUN;
                  end
               end
            end
         endcase
      end
   end

   // one rom read per cycle, msb of the counter marks the end
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_cnt_q      <= '0;
         rom_r_valid_o <= 1'b0;
         wr_pend_q     <= 1'b0;
         rvalid_q      <= 1'b0;
      end else begin
         rom_r_valid_o <= (state_q == BOOT_COPY) && !rd_cnt_q[BOOTROM_ADDR_W-2];
         if ((state_q == BOOT_COPY) && !rd_cnt_q[BOOTROM_ADDR_W-2]) begin
            rd_cnt_q <= rd_cnt_q + 1'b1;
         end
         wr_pend_q <= rom_r_valid_o;
         rvalid_q  <= req_i.valid && !(|req_i.wstrb);
      end
   end

   always_ff @(posedge clk_i) begin
      rom_r_addr_o <= rd_cnt_q[BOOTROM_ADDR_W-3:0];
      wr_idx_q     <= rom_r_addr_o;
   end

   // rom data goes straight into the sram write
   assign preload_req_o.valid = wr_pend_q;
   assign preload_req_o.addr  = PRELOAD_BASE + ADDR_W'({wr_idx_q, 2'b00});
   assign preload_req_o.wdata = rom_r_rdata_i;
   assign preload_req_o.wstrb = '1;

   assign boot_o      = boot_q;
   assign cpu_reset_o = (state_q == BOOT_COPY) || (state_q == BOOT_RESET);

   assign resp_o.ready  = 1'b1;
   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = {{(DATA_W - 2){1'b0}}, cpu_reset_o, boot_o};

   a_preload_only_in_copy: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      preload_req_o.valid |-> (state_q == BOOT_COPY)
   );

endmodule

// ==== source/int_mem_dbus_split.sv ====
module int_mem_dbus_split
   import int_mem_pkg::*;
#(
   parameter int B_BIT          = 31,
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 8
) (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  iob_req_t  m_req_i,
   output iob_resp_t m_resp_o,
   output iob_req_t  boot_req_o,
   input  iob_resp_t boot_resp_i,
   output iob_req_t  ram_req_o,
   input  iob_resp_t ram_resp_i,
   input  logic      boot_i
);

   // minus the rom size in sram words
   localparam logic [SRAM_ADDR_W-3:0] BOOT_OFFSET =
      (SRAM_ADDR_W-2)'(-(2**(BOOTROM_ADDR_W-2)));

   logic                   sel_boot;
   logic                   blocked;
   logic                   rd_accept;
   logic                   pend_q;
   logic                   pend_boot_q;
   logic [SRAM_ADDR_W-3:0] ram_word;

   assign sel_boot = m_req_i.addr[B_BIT];

   // a read to the other target still owes its response
   assign blocked = pend_q && (pend_boot_q != sel_boot);

   assign ram_word = m_req_i.addr[SRAM_ADDR_W-1:2] + (boot_i ? BOOT_OFFSET : '0);

   always_comb begin
      boot_req_o       = m_req_i;
      boot_req_o.valid = m_req_i.valid && sel_boot && !blocked;
      ram_req_o        = m_req_i;
      ram_req_o.valid  = m_req_i.valid && !sel_boot && !blocked;
      ram_req_o.addr   = ADDR_W'({ram_word, 2'b00});
   end

   assign m_resp_o.ready = !blocked && (sel_boot ? boot_resp_i.ready : ram_resp_i.ready);
   assign rd_accept      = m_req_i.valid && m_resp_o.ready && !(|m_req_i.wstrb);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pend_q      <= 1'b0;
         pend_boot_q <= 1'b0;
      end else begin
         pend_q <= rd_accept;
         if (rd_accept) begin
            pend_boot_q <= sel_boot;
         end
      end
   end

   // response follows the target of the last read
   assign m_resp_o.rdata  = pend_boot_q ? boot_resp_i.rdata : ram_resp_i.rdata;
   assign m_resp_o.rvalid = pend_boot_q ? boot_resp_i.rvalid : ram_resp_i.rvalid;

   a_single_rvalid: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      !(boot_resp_i.rvalid && ram_resp_i.rvalid)
   );

endmodule

// ==== source/int_mem_ibus_arbiter.sv ====
module int_mem_ibus_arbiter
   import int_mem_pkg::*;
#(
   parameter int BOOTROM_ADDR_W = 8
) (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  iob_req_t  preload_req_i,
   input  iob_req_t  cpu_req_i,
   output iob_resp_t cpu_resp_o,
   output iob_req_t  ram_req_o,
   input  iob_resp_t ram_resp_i,
   input  logic      boot_i
);

   localparam logic [ADDR_W-1:0] BOOT_OFFSET = ADDR_W'(2**BOOTROM_ADDR_W);

   logic seen_q;
   logic preloading;
   logic cpu_grant;
   logic owner_cpu_q;

   // preload runs until its write stream has started and ended
   assign preloading = !seen_q || preload_req_i.valid;

   assign cpu_grant = cpu_req_i.valid && !preloading && ram_resp_i.ready;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         seen_q      <= 1'b0;
         owner_cpu_q <= 1'b0;
      end else begin
         seen_q      <= seen_q || preload_req_i.valid;
         owner_cpu_q <= cpu_grant;
      end
   end

   always_comb begin
      if (preload_req_i.valid) begin
         ram_req_o = preload_req_i;
      end else begin
         ram_req_o.valid = cpu_req_i.valid && !preloading;
         // shift down by the rom size so cpu address 0 hits the boot code
         ram_req_o.addr  = boot_i ? (cpu_req_i.addr - BOOT_OFFSET) : cpu_req_i.addr;
         ram_req_o.wdata = cpu_req_i.wdata;
         ram_req_o.wstrb = '0;
      end
   end

   assign cpu_resp_o.ready  = !preloading && ram_resp_i.ready;
   assign cpu_resp_o.rvalid = owner_cpu_q && ram_resp_i.rvalid;
   assign cpu_resp_o.rdata  = ram_resp_i.rdata;

   a_cpu_read_only: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      cpu_req_i.valid |-> (cpu_req_i.wstrb == '0)
   );

endmodule

// ==== source/int_mem_sram.sv ====
module int_mem_sram
   import int_mem_pkg::*;
#(
   parameter int SRAM_ADDR_W = 12
) (
   input  logic      clk_i,
   input  iob_req_t  i_req_i,
   output iob_resp_t i_resp_o,
   input  iob_req_t  d_req_i,
   output iob_resp_t d_resp_o
);

   localparam int DEPTH = 2**(SRAM_ADDR_W - 2);

   logic [DATA_W-1:0]      mem [DEPTH];
   logic [SRAM_ADDR_W-3:0] i_idx;
   logic [SRAM_ADDR_W-3:0] d_idx;
   logic [DATA_W-1:0]      i_rdata_q;
   logic [DATA_W-1:0]      d_rdata_q;
   logic                   i_rvalid_q;
   logic                   d_rvalid_q;

   // upper address bits fold onto the array
   assign i_idx = i_req_i.addr[SRAM_ADDR_W-1:2];
   assign d_idx = d_req_i.addr[SRAM_ADDR_W-1:2];

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
         if (i_req_i.valid && i_req_i.wstrb[b]) begin
            mem[i_idx][b*8 +: 8] <= i_req_i.wdata[b*8 +: 8];
         end
         if (d_req_i.valid && d_req_i.wstrb[b]) begin
            mem[d_idx][b*8 +: 8] <= d_req_i.wdata[b*8 +: 8];
         end
      end
      i_rdata_q  <= mem[i_idx];
      d_rdata_q  <= mem[d_idx];
      i_rvalid_q <= i_req_i.valid && !(|i_req_i.wstrb);
      d_rvalid_q <= d_req_i.valid && !(|d_req_i.wstrb);
   end

   assign i_resp_o.ready  = 1'b1;
   assign i_resp_o.rvalid = i_rvalid_q;
   assign i_resp_o.rdata  = i_rdata_q;
   assign d_resp_o.ready  = 1'b1;
   assign d_resp_o.rvalid = d_rvalid_q;
   assign d_resp_o.rdata  = d_rdata_q;

   a_no_write_collision: assert property (
      @(posedge clk_i)
      (i_req_i.valid && (|i_req_i.wstrb) && d_req_i.valid && (|d_req_i.wstrb))
         |-> (i_idx != d_idx)
   );

endmodule

// ==== source/int_mem.sv ====
module int_mem
   import int_mem_pkg::*;
#(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 8,
   parameter int B_BIT          = 31,
   parameter int RESET_PULSE    = 4
) (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   // instruction bus, reads only
   input  iob_req_t                  i_req_i,
   output iob_resp_t                 i_resp_o,
   // data bus
   input  iob_req_t                  d_req_i,
   output iob_resp_t                 d_resp_o,
   // boot rom, one cycle read latency
   output logic                      rom_r_valid_o,
   output logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  logic [DATA_W-1:0]         rom_r_rdata_i,
   output logic                      boot_o,
   output logic                      cpu_reset_o
);

   iob_req_t  boot_req;
   iob_resp_t boot_resp;
   iob_req_t  ram_d_req;
   iob_resp_t ram_d_resp;
   iob_req_t  preload_req;
   iob_req_t  ram_i_req;
   iob_resp_t ram_i_resp;

   int_mem_dbus_split #(
      .B_BIT         (B_BIT),
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W)
   ) u_dbus_split (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .m_req_i    (d_req_i),
      .m_resp_o   (d_resp_o),
      .boot_req_o (boot_req),
      .boot_resp_i(boot_resp),
      .ram_req_o  (ram_d_req),
      .ram_resp_i (ram_d_resp),
      .boot_i     (boot_o)
   );

   int_mem_boot_ctrl #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W),
      .RESET_PULSE   (RESET_PULSE)
   ) u_boot_ctrl (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req_i        (boot_req),
      .resp_o       (boot_resp),
      .preload_req_o(preload_req),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .boot_o       (boot_o),
      .cpu_reset_o  (cpu_reset_o)
   );

   // preload writes share the instruction port with cpu fetches
   int_mem_ibus_arbiter #(
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W)
   ) u_ibus_arbiter (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .preload_req_i(preload_req),
      .cpu_req_i    (i_req_i),
      .cpu_resp_o   (i_resp_o),
      .ram_req_o    (ram_i_req),
      .ram_resp_i   (ram_i_resp),
      .boot_i       (boot_o)
   );

   int_mem_sram #(
      .SRAM_ADDR_W(SRAM_ADDR_W)
   ) u_sram (
      .clk_i   (clk_i),
      .i_req_i (ram_i_req),
      .i_resp_o(ram_i_resp),
      .d_req_i (ram_d_req),
      .d_resp_o(ram_d_resp)
   );

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #5 clk_o = ~clk_o;
      end
   end

   // reset held over four rising edges, released mid cycle
   initial begin
      arst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule

// ==== tb/tb_int_mem.sv ====
module tb_int_mem
   import int_mem_pkg::*;
();

   localparam int SRAM_ADDR_W    = 12;
   localparam int BOOTROM_ADDR_W = 8;
   localparam int B_BIT          = 31;
   localparam int RESET_PULSE    = 4;
   localparam int ROM_WORDS      = 2**(BOOTROM_ADDR_W - 2);
   localparam int TIMEOUT        = 200;
   localparam logic [ADDR_W-1:0] REG_ADDR  = ADDR_W'(1) << B_BIT;
   // one rom size up so the boot remap lands on sram word 0
   localparam logic [ADDR_W-1:0] DATA_BASE = ADDR_W'(2**BOOTROM_ADDR_W);
   localparam logic [ADDR_W-1:0] TOP_BASE  = ADDR_W'(2**SRAM_ADDR_W - 2**BOOTROM_ADDR_W);

   logic                      clk;
   logic                      arst_n;
   iob_req_t                  i_req;
   iob_resp_t                 i_resp;
   iob_req_t                  d_req;
   iob_resp_t                 d_resp;
   logic                      rom_r_valid;
   logic [BOOTROM_ADDR_W-3:0] rom_r_addr;
   logic [DATA_W-1:0]         rom_r_rdata;
   logic                      boot;
   logic                      cpu_reset;
   logic [DATA_W-1:0]         ref_ram [2**(SRAM_ADDR_W-2)];
   logic [ADDR_W-1:0]         addr_buf [128];
   iob_resp_t                 resp_buf [128];
   int                        stalls;
   logic [31:0]               rng = 32'd61;

   tb_clk_gen u_clk_gen (
      .clk_o   (clk),
      .arst_n_o(arst_n)
   );

   int_mem #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W),
      .B_BIT         (B_BIT),
      .RESET_PULSE   (RESET_PULSE)
   ) u_dut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .i_req_i      (i_req),
      .i_resp_o     (i_resp),
      .d_req_i      (d_req),
      .d_resp_o     (d_resp),
      .rom_r_valid_o(rom_r_valid),
      .rom_r_addr_o (rom_r_addr),
      .rom_r_rdata_i(rom_r_rdata),
      .boot_o       (boot),
      .cpu_reset_o  (cpu_reset)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [DATA_W-1:0] rom_word(input int idx);
      logic [31:0] x;
      x = 32'd61;
      for (int n = 0; n <= idx; n++) begin
         x = lcg_next(x);
      end
      return x;
   endfunction

   // sram word seen by a cpu address shifted down one rom size in boot
   function automatic int remap(input logic [ADDR_W-1:0] addr, input logic in_boot);
      logic [ADDR_W-1:0] phys;
      phys = in_boot ? addr - ADDR_W'(2**BOOTROM_ADDR_W) : addr;
      return int'(phys[SRAM_ADDR_W-1:2]);
   endfunction

   function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old,
                                              input logic [DATA_W-1:0] wdata,
                                              input logic [DATA_W/8-1:0] wstrb);
      logic [DATA_W-1:0] res;
      res = old;
      for (int b = 0; b < DATA_W / 8; b++) begin
         if (wstrb[b]) begin
            res[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // boot rom with one cycle read latency
   always @(posedge clk) begin
      if (rom_r_valid) begin
         rom_r_rdata <= rom_word(rom_r_addr);
      end
   end

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic check_resp(input string name, input logic [DATA_W-1:0] exp,
                             input iob_resp_t act);
      if (act.rdata !== exp) begin
         fail_now($sformatf("mismatch %s expected %h actual %h", name, exp, act.rdata));
      end
   endtask

   task automatic check_status(input string name, input logic exp_boot, input logic exp_reset);
      if ({boot, cpu_reset} !== {exp_boot, exp_reset}) begin
         fail_now($sformatf("mismatch %s expected boot/reset %b%b actual %b%b",
                            name, exp_boot, exp_reset, boot, cpu_reset));
      end
   endtask

   task automatic drive_req(input logic dbus, input iob_req_t req);
      if (dbus) begin
         d_req <= req;
      end else begin
         i_req <= req;
      end
   endtask

   task automatic d_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                          input logic [DATA_W/8-1:0] wstrb);
      iob_req_t req;
      int       waited;
      req.valid = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      waited    = 0;
      @(posedge clk);
      d_req <= req;
      do begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            fail_now("data write was never accepted");
         end
      end while (!d_resp.ready);
      req.valid = 1'b0;
      d_req <= req;
   endtask

   // pipelined reads of addr_buf[0..n-1] with responses into resp_buf
   task automatic read_burst(input logic dbus, input int n);
      iob_req_t  req;
      iob_resp_t resp;
      int        issued;
      int        got;
      int        waited;
      issued    = 0;
      got       = 0;
      waited    = 0;
      stalls    = 0;
      req       = '0;
      req.valid = 1'b1;
      req.addr  = addr_buf[0];
      @(posedge clk);
      drive_req(dbus, req);
      while (got < n) begin
         @(posedge clk);
         resp = dbus ? d_resp : i_resp;
         if (resp.rvalid) begin
            resp_buf[got] = resp;
            got++;
         end
         if ((issued < n) && resp.ready) begin
            issued++;
            req.valid = (issued < n);
            req.addr  = addr_buf[issued % n];
            drive_req(dbus, req);
         end else if (issued < n) begin
            stalls++;
         end
         waited++;
         if (waited > TIMEOUT) begin
            fail_now("read burst stalled waiting for ready or rvalid");
         end
      end
   endtask

   initial begin
      int                  waited;
      int                  pulse;
      int                  word;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
      iob_req_t            req;
      i_req       = '0;
      d_req       = '0;
      rom_r_rdata = '0;
      waited      = 0;
      do begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            fail_now("reset was never released");
         end
      end while (!arst_n);
      check_status("after reset", 1'b1, 1'b1);
      if ({rom_r_valid, i_resp.rvalid, d_resp.rvalid} !== 3'b000) begin
         fail_now("rom valid or a bus rvalid is not low after reset");
      end
      // fetch held during preload must stay unaccepted
      req       = '0;
      req.valid = 1'b1;
      drive_req(1'b0, req);
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
         if (waited > ROM_WORDS + 8) begin
            fail_now("cpu reset did not fall after the preload");
         end
         if (cpu_reset && i_resp.ready) begin
            fail_now("instruction read accepted during the preload");
         end
      end while (cpu_reset);
      if (!i_resp.ready) begin
         fail_now("instruction read not accepted after the preload");
      end
      req.valid = 1'b0;
      drive_req(1'b0, req);
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            fail_now("no rvalid for the first instruction read");
         end
      end while (!i_resp.rvalid);
      check_resp("first fetch", rom_word(0), i_resp);
      check_status("preload done", 1'b1, 1'b0);
      for (int k = 0; k < ROM_WORDS; k++) begin
         ref_ram[remap(TOP_BASE + ADDR_W'(4 * k), 1'b0)] = rom_word(k);
         addr_buf[k] = ADDR_W'(4 * k);
      end
      read_burst(1'b0, ROM_WORDS);
      for (int k = 0; k < ROM_WORDS; k++) begin
         check_resp($sformatf("boot fetch %0d", k), rom_word(k), resp_buf[k]);
      end
      // full word first and then a random strobe merge on top
      for (int k = 0; k < 8; k++) begin
         addr_buf[k] = DATA_BASE + ADDR_W'(4 * k);
         word = remap(addr_buf[k], 1'b1);
         rng  = lcg_next(rng);
         d_write(addr_buf[k], rng, '1);
         ref_ram[word] = rng;
         rng   = lcg_next(rng);
         wdata = rng;
         rng   = lcg_next(rng);
         wstrb = rng[31:28];
         if (wstrb == '0) begin
            wstrb = 4'h1;
         end
         d_write(addr_buf[k], wdata, wstrb);
         ref_ram[word] = merge(ref_ram[word], wdata, wstrb);
      end
      read_burst(1'b1, 8);
      for (int k = 0; k < 8; k++) begin
         check_resp($sformatf("boot data %0d", k), ref_ram[remap(addr_buf[k], 1'b1)],
                    resp_buf[k]);
      end
      // sram then register then sram makes the split wait on each switch
      addr_buf[0] = DATA_BASE;
      addr_buf[1] = REG_ADDR;
      addr_buf[2] = DATA_BASE + ADDR_W'(4);
      read_burst(1'b1, 3);
      check_resp("mixed sram 0", ref_ram[remap(addr_buf[0], 1'b1)], resp_buf[0]);
      check_resp("register in boot", 32'h1, resp_buf[1]);
      check_resp("mixed sram 1", ref_ram[remap(addr_buf[2], 1'b1)], resp_buf[2]);
      // each switch with a read in flight costs one cycle of ready
      if (stalls != 2) begin
         fail_now($sformatf("mismatch split stalls expected %0d actual %0d", 2, stalls));
      end
      d_write(REG_ADDR, '0, '1);
      @(posedge clk);
      check_status("leave boot", 1'b0, 1'b0);
      for (int k = 0; k < 8; k++) begin
         addr_buf[k] = ADDR_W'(4 * k);
      end
      for (int k = 0; k < ROM_WORDS; k++) begin
         addr_buf[8 + k] = TOP_BASE + ADDR_W'(4 * k);
      end
      read_burst(1'b0, 8 + ROM_WORDS);
      for (int k = 0; k < 8 + ROM_WORDS; k++) begin
         check_resp($sformatf("run fetch %0d", k), ref_ram[remap(addr_buf[k], 1'b0)],
                    resp_buf[k]);
      end
      addr_buf[0] = REG_ADDR;
      read_burst(1'b1, 1);
      check_resp("register in run", 32'h0, resp_buf[0]);
      // reset request with the boot bit kept at zero
      d_write(REG_ADDR, 32'h2, '1);
      pulse  = 0;
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
         if (waited > TIMEOUT) begin
            fail_now("cpu reset pulse never ended");
         end
         if (cpu_reset) begin
            pulse++;
         end
      end while (cpu_reset || (pulse == 0));
      if (pulse != RESET_PULSE) begin
         fail_now($sformatf("mismatch reset pulse expected %0d actual %0d",
                            RESET_PULSE, pulse));
      end
      check_status("after reset pulse", 1'b0, 1'b0);
      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== flist.f ====
source/int_mem_pkg.sv
source/int_mem_boot_ctrl.sv
source/int_mem_dbus_split.sv
source/int_mem_ibus_arbiter.sv
source/int_mem_sram.sv
source/int_mem.sv
tb/tb_clk_gen.sv
tb/tb_int_mem.sv
